//--- Makefile
# Verilator build and run for the instruction front end

VERILATOR ?= verilator
TOP       ?= tb_core_frontend
FILELIST  ?= core_frontend.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '** PASS **' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/frontend_checks.svh
`ifndef FRONTEND_CHECKS_SVH
`define FRONTEND_CHECKS_SVH

int errors = 0;
int checks = 0;

task automatic check_word(input string name, input logic [XLEN-1:0] expected,
                          input logic [XLEN-1:0] actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
  end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("Fail at %0t: %s expected %b got %b", $time, name, expected, actual);
  end
endtask

task automatic report_error(input string what);
  errors++;
  $display("Error at %0t: %s", $time, what);
endtask

// memory content: the address with its upper half inverted
function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
  return {~addr[XLEN-1:XLEN/2], addr[XLEN/2-1:0]};
endfunction

function automatic logic [GROUP_BITS-1:0] group_data(input logic [XLEN-1:0] addr);
  logic [GROUP_BITS-1:0] data;
  for (int k = 0; k < FETCH_WIDTH; k++) begin
    data[k*XLEN +: XLEN] = mem_word(addr + XLEN'(k * (XLEN / 8)));
  end
  return data;
endfunction

`endif

//--- bench/tb_core_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_frontend
  import frontend_pkg::*;
();

  `include "frontend_checks.svh"

  // cycle budget of each test
  localparam int RESET_LEN     = 40;
  localparam int STREAM_LEN    = 300;
  localparam int HOLD_LEN      = 200;
  localparam int UNALIGNED_LEN = 120;
  localparam int JUMPS_LEN     = 400;
  localparam int CYCLE_LIMIT   =
    4 * (RESET_LEN + STREAM_LEN + HOLD_LEN + UNALIGNED_LEN + JUMPS_LEN);

  logic                  aclk = 1'b0;
  logic                  reset = 1'b1;
  logic                  jump_valid0 = 1'b0;
  logic [XLEN-1:0]       jump_pc0 = '0;
  logic                  jump_valid1 = 1'b0;
  logic [XLEN-1:0]       jump_pc1 = '0;
  logic                  fetch_req;
  logic [XLEN-1:0]       fetch_addr;
  logic                  fetch_ret = 1'b0;
  logic [GROUP_BITS-1:0] fetch_data = '0;
  logic [XLEN-1:0]       instr0;
  logic [XLEN-1:0]       instr0_pc;
  logic                  instr0_valid;
  logic [XLEN-1:0]       instr1;
  logic [XLEN-1:0]       instr1_pc;
  logic                  instr1_valid;
  logic [1:0]            pop_count = 2'd0;

  // requests from the test tasks to the driver
  logic                  pop_enable = 1'b0;
  logic                  pend_jv0 = 1'b0;
  logic [XLEN-1:0]       pend_jp0 = '0;
  logic                  pend_jv1 = 1'b0;
  logic [XLEN-1:0]       pend_jp1 = '0;
  int                    jump_req_id = 0;

  // reference model state, written by the driver only
  int                    jump_done_id = 0;
  int                    occ = 0;
  logic [XLEN-1:0]       exp_pc = RESET_PC;
  logic [XLEN-1:0]       exp_fetch = RESET_PC;
  logic [1:0]            exp_slot = 2'd0;
  logic                  mem_busy = 1'b0;
  logic                  mem_drop = 1'b0;
  int                    mem_wait = 0;
  logic [XLEN-1:0]       mem_addr = '0;
  logic [1:0]            mem_slot = 2'd0;
  logic                  need_first = 1'b0;
  logic [XLEN-1:0]       first_pc = '0;
  logic                  target_due = 1'b0;
  int                    pop_total = 0;
  int                    req_total = 0;
  int                    cycles = 0;

  core_frontend uut (
    .aclk         (aclk),
    .reset        (reset),
    .jump_valid0  (jump_valid0),
    .jump_pc0     (jump_pc0),
    .jump_valid1  (jump_valid1),
    .jump_pc1     (jump_pc1),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .fetch_ret    (fetch_ret),
    .fetch_data   (fetch_data),
    .instr0       (instr0),
    .instr0_pc    (instr0_pc),
    .instr0_valid (instr0_valid),
    .instr1       (instr1),
    .instr1_pc    (instr1_pc),
    .instr1_valid (instr1_valid),
    .pop_count    (pop_count)
  );

  always #10 aclk = ~aclk;

  task automatic take_entry(input string lane, input logic [XLEN-1:0] pc,
                            input logic [XLEN-1:0] word);
    if (need_first) begin
      first_pc   = pc;
      need_first = 1'b0;
    end
    check_word({lane, "_pc"}, exp_pc, pc);
    check_word(lane, mem_word(exp_pc), word);
    exp_pc = exp_pc + XLEN'(XLEN / 8);
    pop_total++;
  endtask

  // memory, decode and redirect driver with the reference model
  always @(negedge aclk) begin : driver
    logic            jumped;
    logic [XLEN-1:0] target;
    logic            due_now;
    int              cur_occ;
    int              valid_n;
    int              taken;
    int              push_n;

    jumped = 1'b0;
    if (jump_req_id != jump_done_id) begin
      jump_valid0  = pend_jv0;
      jump_pc0     = pend_jp0;
      jump_valid1  = pend_jv1;
      jump_pc1     = pend_jp1;
      jump_done_id = jump_req_id;
      jumped       = pend_jv0 | pend_jv1;
    end else begin
      jump_valid0 = 1'b0;
      jump_valid1 = 1'b0;
    end
    // pipe 0 wins when both jump
    target = jump_valid0 ? jump_pc0 : jump_pc1;

    cur_occ = occ;
    check_bit("instr0_valid", cur_occ > 0, instr0_valid);
    check_bit("instr1_valid", cur_occ > 1, instr1_valid);

    fetch_ret = 1'b0;
    push_n    = 0;
    if (mem_busy) begin
      if (mem_wait == 0) begin
        fetch_ret  = 1'b1;
        fetch_data = group_data(mem_addr);
        mem_busy   = 1'b0;
        if (!mem_drop && !jumped) begin
          push_n = FETCH_WIDTH - int'(mem_slot);
        end
      end else begin
        mem_wait--;
      end
    end
    if (jumped && mem_busy) begin
      mem_drop = 1'b1;
    end

    valid_n   = (cur_occ > 1) ? 2 : cur_occ;
    taken     = 0;
    pop_count = 2'd0;
    if (pop_enable && !jumped) begin
      pop_count = 2'($urandom_range(0, 2));
      taken     = (int'(pop_count) > valid_n) ? valid_n : int'(pop_count);
    end
    if (taken > 0) begin
      take_entry("instr0", instr0_pc, instr0);
    end
    if (taken > 1) begin
      take_entry("instr1", instr1_pc, instr1);
    end

    if (jumped) begin
      occ        = 0;
      exp_pc     = target;
      exp_fetch  = {target[XLEN-1:GROUP_LSB], {GROUP_LSB{1'b0}}};
      exp_slot   = target[GROUP_LSB-1:BYTE_OFFSET_W];
      need_first = 1'b1;
    end else begin
      occ = cur_occ + push_n - taken;
    end
    if (occ > IB_DEPTH) begin
      report_error("instruction buffer took more entries than it holds");
    end

    // target fetch goes out the cycle after nothing is left in flight
    due_now    = target_due;
    target_due = (jumped && !mem_busy) || (fetch_ret && mem_drop && !jumped);

    #1;
    if (due_now && !jumped && !fetch_req) begin
      report_error("no fetch for the jump target in the cycle it was due");
    end
    if (fetch_req) begin
      if (mem_busy || fetch_ret) begin
        report_error("fetch request issued while another is outstanding");
      end
      if (cur_occ > IB_DEPTH - FETCH_WIDTH) begin
        report_error("fetch request issued without room for a whole group");
      end
      if (fetch_addr[GROUP_LSB-1:0] != '0) begin
        report_error("fetch address is not group aligned");
      end
      check_word("fetch_addr", exp_fetch, fetch_addr);
      mem_busy  = 1'b1;
      mem_drop  = 1'b0;
      mem_addr  = fetch_addr;
      mem_slot  = exp_slot;
      mem_wait  = $urandom_range(1, 4) - 1;
      exp_slot  = 2'd0;
      exp_fetch = exp_fetch + XLEN'(FETCH_WIDTH * (XLEN / 8));
      req_total++;
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      report_and_finish(1'b1);
    end
  end

  task automatic settle();
    @(negedge aclk);
    #2;
  endtask

  task automatic wait_pops(input int n);
    int target;
    target = pop_total + n;
    while (pop_total < target) begin
      settle();
    end
  endtask

  // returns once the first instruction after the redirect was popped
  task automatic issue_jump(input logic v0, input logic [XLEN-1:0] pc0,
                            input logic v1, input logic [XLEN-1:0] pc1);
    pend_jv0 = v0;
    pend_jp0 = pc0;
    pend_jv1 = v1;
    pend_jp1 = pc1;
    jump_req_id++;
    while (jump_done_id != jump_req_id) begin
      settle();
    end
    settle();
    check_bit("instr0_valid", 1'b0, instr0_valid);
    check_bit("instr1_valid", 1'b0, instr1_valid);
    while (need_first) begin
      settle();
    end
  endtask

  task automatic reset_state();
    // reset spans 16 clock periods
    for (int i = 0; i < 15; i++) begin
      settle();
      check_bit("fetch_req", 1'b0, fetch_req);
      check_bit("instr0_valid", 1'b0, instr0_valid);
      check_bit("instr1_valid", 1'b0, instr1_valid);
    end
    @(negedge aclk);
    reset = 1'b0;
    #2;
    check_bit("fetch_req", 1'b0, fetch_req);
    settle();
    check_bit("fetch_req", 1'b1, fetch_req);
    check_word("fetch_addr", RESET_PC, fetch_addr);
  endtask

  task automatic sequential_stream();
    pop_enable = 1'b1;
    wait_pops(80);
  endtask

  task automatic decode_backpressure();
    int reqs;
    pop_enable = 1'b0;
    while (occ <= IB_DEPTH - FETCH_WIDTH || mem_busy) begin
      settle();
    end
    reqs = req_total;
    // the two oldest entries stay on the outputs
    repeat (24) begin
      settle();
      check_word("instr0_pc", exp_pc, instr0_pc);
      check_word("instr0", mem_word(exp_pc), instr0);
      check_word("instr1_pc", exp_pc + XLEN'(XLEN / 8), instr1_pc);
      check_word("instr1", mem_word(exp_pc + XLEN'(XLEN / 8)), instr1);
    end
    if (req_total != reqs) begin
      report_error("fetching went on while decode was stalled");
    end
    pop_enable = 1'b1;
    wait_pops(40);
  endtask

  task automatic unaligned_jump();
    logic [XLEN-1:0] target;
    target     = 32'h1c00_4008;
    pop_enable = 1'b0;
    while (occ < FETCH_WIDTH) begin
      settle();
    end
    pop_enable = 1'b1;
    issue_jump(1'b1, target, 1'b0, '0);
    check_word("first popped pc", target, first_pc);
    wait_pops(12);
  endtask

  task automatic jump_priority();
    // redirect while a fetch is still on its way
    while (!(mem_busy && mem_wait >= 1)) begin
      settle();
    end
    issue_jump(1'b1, 32'h1c00_8000, 1'b0, '0);
    check_word("first popped pc", 32'h1c00_8000, first_pc);
    wait_pops(10);

    issue_jump(1'b1, 32'h1c01_0004, 1'b1, 32'h1c02_000c);
    check_word("first popped pc", 32'h1c01_0004, first_pc);
    wait_pops(10);

    issue_jump(1'b0, '0, 1'b1, 32'h1c03_0008);
    check_word("first popped pc", 32'h1c03_0008, first_pc);
    wait_pops(10);
  endtask

  task automatic report_and_finish(input bit timed_out);
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(32'ha7c5_9fa5));
    reset_state();
    sequential_stream();
    decode_backpressure();
    unaligned_jump();
    jump_priority();
    report_and_finish(1'b0);
  end

endmodule

`default_nettype wire

//--- core_frontend.f
+incdir+bench
design/frontend_pkg.sv
design/fetch_pc_gen.sv
design/fetch_align.sv
design/instr_buffer.sv
design/core_frontend.sv
bench/tb_core_frontend.sv

//--- design/core_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module core_frontend
  import frontend_pkg::*;
(
  input  wire                  aclk,
  input  wire                  reset,
  // redirect from the two execute pipes
  input  wire                  jump_valid0,
  input  wire [XLEN-1:0]       jump_pc0,
  input  wire                  jump_valid1,
  input  wire [XLEN-1:0]       jump_pc1,
  // memory port
  output logic                 fetch_req,
  output logic [XLEN-1:0]      fetch_addr,
  input  wire                  fetch_ret,
  input  wire [GROUP_BITS-1:0] fetch_data,
  // decode port
  output logic [XLEN-1:0]      instr0,
  output logic [XLEN-1:0]      instr0_pc,
  output logic                 instr0_valid,
  output logic [XLEN-1:0]      instr1,
  output logic [XLEN-1:0]      instr1_pc,
  output logic                 instr1_valid,
  input  wire [1:0]            pop_count
);

  logic                        flush;
  logic                        ret_accept;
  logic [GROUP_OFFSET_W-1:0]   start_slot;
  logic [XLEN-1:0]             group_pc;
  logic [GROUP_BITS-1:0]       push_words;
  logic [XLEN*FETCH_WIDTH-1:0] push_pcs;
  logic [2:0]                  push_num;
  logic [IB_COUNT_W-1:0]       free_count;

  fetch_pc_gen u_pc_gen (
    .aclk        (aclk),
    .reset       (reset),
    .jump_valid0 (jump_valid0),
    .jump_pc0    (jump_pc0),
    .jump_valid1 (jump_valid1),
    .jump_pc1    (jump_pc1),
    .fetch_ret   (fetch_ret),
    .free_count  (free_count),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .flush       (flush),
    .ret_accept  (ret_accept),
    .start_slot  (start_slot),
    .group_pc    (group_pc)
  );

  fetch_align u_align (
    .fetch_data (fetch_data),
    .start_slot (start_slot),
    .group_pc   (group_pc),
    .ret_accept (ret_accept),
    .push_words (push_words),
    .push_pcs   (push_pcs),
    .push_num   (push_num)
  );

  instr_buffer u_ibuf (
    .aclk         (aclk),
    .reset        (reset),
    .flush        (flush),
    .push_words   (push_words),
    .push_pcs     (push_pcs),
    .push_num     (push_num),
    .pop_count    (pop_count),
    .instr0       (instr0),
    .instr0_pc    (instr0_pc),
    .instr1       (instr1),
    .instr1_pc    (instr1_pc),
    .instr0_valid (instr0_valid),
    .instr1_valid (instr1_valid),
    .free_count   (free_count)
  );

endmodule

`default_nettype wire

//--- design/fetch_align.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_align
  import frontend_pkg::*;
(
  input  wire [GROUP_BITS-1:0]        fetch_data,
  input  wire [GROUP_OFFSET_W-1:0]    start_slot,
  input  wire [XLEN-1:0]              group_pc,
  input  wire                         ret_accept,
  output logic [GROUP_BITS-1:0]       push_words,
  output logic [XLEN*FETCH_WIDTH-1:0] push_pcs,
  output logic [2:0]                  push_num
);

  // entries from the start slot onward, oldest in lane 0
  for (genvar k = 0; k < FETCH_WIDTH; k++) begin : g_lane
    logic [GROUP_OFFSET_W:0]   src;
    logic                      live;
    logic [GROUP_OFFSET_W-1:0] sel;
    logic [XLEN-1:0]           word;
    logic [XLEN-1:0]           pc;

    assign src  = {1'b0, start_slot} + (GROUP_OFFSET_W + 1)'(k);
    assign live = src < (GROUP_OFFSET_W + 1)'(FETCH_WIDTH);
    assign sel  = src[GROUP_OFFSET_W-1:0];

    assign word = fetch_data[sel*XLEN +: XLEN];

    // pc of the source slot inside the group
    assign pc = group_pc + (XLEN'(sel) << BYTE_OFFSET_W);

    // lanes past the group end carry nothing
    assign push_words[k*XLEN +: XLEN] = live ? word : '0;
    assign push_pcs[k*XLEN +: XLEN]   = live ? pc : '0;
  end

  // slots before the start were skipped by the jump target
  always_comb begin
    if (ret_accept) begin
      push_num = 3'(FETCH_WIDTH) - 3'(start_slot);
    end else begin
      push_num = 3'd0;
    end
  end

endmodule

`default_nettype wire

//--- design/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen
  import frontend_pkg::*;
(
  input  wire                      aclk,
  input  wire                      reset,
  input  wire                      jump_valid0,
  input  wire [XLEN-1:0]           jump_pc0,
  input  wire                      jump_valid1,
  input  wire [XLEN-1:0]           jump_pc1,
  input  wire                      fetch_ret,
  input  wire [IB_COUNT_W-1:0]     free_count,
  output logic                     fetch_req,
  output logic [XLEN-1:0]          fetch_addr,
  output logic                     flush,
  output logic                     ret_accept,
  output logic [GROUP_OFFSET_W-1:0] start_slot,
  output logic [XLEN-1:0]          group_pc
);

  logic            running;
  logic            outstanding;
  logic            discard;
  logic [XLEN-1:0] next_pc;
  logic            jump;
  logic [XLEN-1:0] jump_target;
  logic            room;

  // pipe 0 has priority over pipe 1
  assign jump        = jump_valid0 | jump_valid1;
  assign jump_target = jump_valid0 ? jump_pc0 : jump_pc1;
  assign flush       = jump;

  // buffer must be able to take a whole group
  assign room = free_count >= IB_COUNT_W'(FETCH_WIDTH);

  assign fetch_addr = {next_pc[XLEN-1:GROUP_LSB], {GROUP_LSB{1'b0}}};

  // no request in a jump cycle, the target goes out next cycle
  assign fetch_req = running & ~outstanding & room & ~jump;

  // a return is dropped when it belongs to a redirected request
  assign ret_accept = fetch_ret & ~discard & ~jump;

  always_ff @(posedge aclk) begin
    if (reset) begin
      running     <= 1'b0;
      outstanding <= 1'b0;
      discard     <= 1'b0;
      next_pc     <= RESET_PC;
    end else begin
      running <= 1'b1;

      // at most one fetch in flight
      if (fetch_req) begin
        outstanding <= 1'b1;
      end else if (fetch_ret) begin
        outstanding <= 1'b0;
      end

      // return of the in-flight request clears the drop mark
      if (fetch_ret) begin
        discard <= 1'b0;
      end else if (jump && outstanding) begin
        discard <= 1'b1;
      end

      if (jump) begin
        next_pc <= jump_target;
      end else if (fetch_req) begin
        // sequential fetch continues with the following group
        next_pc <= fetch_addr + XLEN'(1 << GROUP_LSB);
      end
    end
  end

  // remember where the requested group starts for the aligner
  always_ff @(posedge aclk) begin
    if (fetch_req) begin
      start_slot <= next_pc[GROUP_LSB-1:BYTE_OFFSET_W];
      group_pc   <= fetch_addr;
    end
  end

endmodule

`default_nettype wire

//--- design/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

  // word and address width
  localparam int XLEN = 32;

  // instructions per fetch group
  localparam int FETCH_WIDTH = 4;

  // instructions offered to decode each cycle
  localparam int ISSUE_WIDTH = 2;

  // one returned fetch group
  localparam int GROUP_BITS = XLEN * FETCH_WIDTH;

  // slot select bits inside a group
  localparam int GROUP_OFFSET_W = 2;

  // byte address bits below one instruction word
  localparam int BYTE_OFFSET_W = $clog2(XLEN / 8);

  // lowest pc bit above the group boundary
  localparam int GROUP_LSB = GROUP_OFFSET_W + BYTE_OFFSET_W;

  // instruction buffer geometry
  localparam int IB_DEPTH = 16;
  localparam int IB_PTR_W = $clog2(IB_DEPTH);

  // occupancy needs one more bit to hold a full count
  localparam int IB_COUNT_W = IB_PTR_W + 1;

  // boot address
  localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

endpackage

`default_nettype wire

//--- design/instr_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module instr_buffer
  import frontend_pkg::*;
(
  input  wire                         aclk,
  input  wire                         reset,
  input  wire                         flush,
  input  wire [GROUP_BITS-1:0]        push_words,
  input  wire [XLEN*FETCH_WIDTH-1:0]  push_pcs,
  input  wire [2:0]                   push_num,
  input  wire [1:0]                   pop_count,
  output logic [XLEN-1:0]             instr0,
  output logic [XLEN-1:0]             instr0_pc,
  output logic [XLEN-1:0]             instr1,
  output logic [XLEN-1:0]             instr1_pc,
  output logic                        instr0_valid,
  output logic                        instr1_valid,
  output logic [IB_COUNT_W-1:0]       free_count
);

  logic [XLEN-1:0]       word_mem [IB_DEPTH];
  logic [XLEN-1:0]       pc_mem   [IB_DEPTH];
  logic [IB_PTR_W-1:0]   head;
  logic [IB_PTR_W-1:0]   tail;
  logic [IB_COUNT_W-1:0] count;
  logic [IB_PTR_W-1:0]   head_plus1;
  logic [IB_PTR_W-1:0]   wr_idx [FETCH_WIDTH];
  logic [1:0]            avail;
  logic [1:0]            pop_num;

  // two oldest entries go to decode
  assign head_plus1 = head + 1'b1;

  assign instr0    = word_mem[head];
  assign instr0_pc = pc_mem[head];
  assign instr1    = word_mem[head_plus1];
  assign instr1_pc = pc_mem[head_plus1];

  assign instr0_valid = count != '0;
  assign instr1_valid = count > IB_COUNT_W'(1);

  assign free_count = IB_COUNT_W'(IB_DEPTH) - count;

  // decode can only take what is shown
  always_comb begin
    if (count >= IB_COUNT_W'(ISSUE_WIDTH)) begin
      avail = 2'(ISSUE_WIDTH);
    end else begin
      avail = 2'(count);
    end
    if (pop_count > avail) begin
      pop_num = avail;
    end else begin
      pop_num = pop_count;
    end
  end

  // write slots, wrapping at the end of the ring
  always_comb begin
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      wr_idx[k] = tail + IB_PTR_W'(k);
    end
  end

  always_ff @(posedge aclk) begin
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      if (k < int'(push_num)) begin
        word_mem[wr_idx[k]] <= push_words[k*XLEN +: XLEN];
        pc_mem[wr_idx[k]]   <= push_pcs[k*XLEN +: XLEN];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      // redirect drops everything queued
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + IB_PTR_W'(pop_num);
      tail  <= tail + IB_PTR_W'(push_num);
      count <= count + IB_COUNT_W'(push_num) - IB_COUNT_W'(pop_num);
    end
  end

endmodule

`default_nettype wire
